/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_zx_io
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/io_ports.sv */
// ULA and DAC port latches

`timescale 1ns/1ns

module io_ports
	import zx_bus_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,

	// CPU bus levels
	input  cpu_addr_t addr,
	input  cpu_data_t data,
	input  logic      io_req,
	input  logic      wr,
	input  logic      m1,

	output logic      io_write_pulse,   // One cycle per I/O write

	// ULA port
	output border_t   border,
	output logic      ear_out,
	output logic      mic_out,

	// Covox and SounDrive latches
	output cpu_data_t dac_l0,
	output cpu_data_t dac_l1,
	output cpu_data_t dac_r0,
	output cpu_data_t dac_r1
);

	logic io_write;
	logic io_write_prev;
	logic ula_sel;
	logic covox_sel;

	// ========================================================================
	// Write edge
	// ========================================================================

	assign io_write = io_req & wr & ~m1;    // Interrupt ack is not a write

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_write_prev <= 1'b0;
		else
			io_write_prev <= io_write;
	end

	// First cycle of the level only, so a held write latches once
	assign io_write_pulse = io_write & ~io_write_prev;

	// ========================================================================
	// Port latches
	// ========================================================================

	assign ula_sel   = ~addr[PORT_ULA_BIT];
	assign covox_sel = (addr[7:0] == PORT_COVOX);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= '0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
			dac_l0  <= '0;
			dac_l1  <= '0;
			dac_r0  <= '0;
			dac_r1  <= '0;
		end else if (io_write_pulse) begin
			if (ula_sel) begin
				border  <= data[2:0];
				ear_out <= data[4];   // Speaker
				mic_out <= data[3];   // Tape out
			end
			// Covox drives all four, SounDrive one each
			if (covox_sel || addr[7:0] == PORT_SD_A) dac_l0 <= data;
			if (covox_sel || addr[7:0] == PORT_SD_B) dac_l1 <= data;
			if (covox_sel || addr[7:0] == PORT_SD_C) dac_r0 <= data;
			if (covox_sel || addr[7:0] == PORT_SD_D) dac_r1 <= data;
		end
	end

endmodule

/* logic/memory_pager.sv */
// 128K and +3 memory paging

`timescale 1ns/1ns

module memory_pager
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  mem_mode_t mem_mode,         // Sampled during reset

	// CPU bus levels
	input  cpu_addr_t addr,
	input  cpu_data_t data,
	input  logic      mem_req,
	input  logic      wr,
	input  logic      io_write_pulse,

	output ram_addr_t ram_addr,
	output logic      ram_we
);

	logic      is_48k;
	logic      is_plus3;
	cpu_data_t page_7ffd;
	cpu_data_t page_1ffd;

	logic      page_disable;
	logic      write_7ffd;
	logic      write_1ffd;
	logic      special;
	logic [1:0] special_cfg;
	logic      rom_sel;
	rom_bank_t rom_page;
	bank_t     bank;

	// ========================================================================
	// Paging registers
	// ========================================================================

	// 48K has no paging at all, bit 5 locks it until reset
	assign page_disable = is_48k | page_7ffd[5];

	// Partial decode as on the real machines
	assign write_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~is_plus3) & ~page_disable;
	assign write_1ffd = is_plus3 & ~page_disable & ~addr[15] & ~addr[14] & ~addr[13]
		& addr[12] & ~addr[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			case (mem_mode)
				MODE_48K:   {is_48k, is_plus3} <= 2'b10;
				MODE_PLUS3: {is_48k, is_plus3} <= 2'b01;
				MODE_128K:  {is_48k, is_plus3} <= 2'b00;
				default:    {is_48k, is_plus3} <= 2'b00;   // Treated as 128K
			endcase
			page_7ffd <= '0;
			page_1ffd <= '0;
		end else if (io_write_pulse) begin
			if (write_7ffd)
				page_7ffd <= data;
			else if (write_1ffd)
				page_1ffd <= data;
		end
	end

	// ========================================================================
	// Address map
	// ========================================================================

	assign special     = page_1ffd[0];      // +3 all-RAM layouts
	assign special_cfg = page_1ffd[2:1];

	// ROM page numbering of the combined ROM image
	assign rom_page = is_plus3 ? {2'b01, page_1ffd[2], page_7ffd[4]}
		: {is_48k, 2'b01, is_48k | page_7ffd[4]};

	always_comb begin
		rom_sel = 1'b0;
		bank    = page_7ffd[2:0];
		if (special) begin
			case (addr[15:14])
				2'd0:    bank = (special_cfg == 2'd0) ? 3'd0 : 3'd4;
				2'd1:    bank = (special_cfg == 2'd0) ? 3'd1
					: (special_cfg == 2'd3) ? 3'd7 : 3'd5;
				2'd2:    bank = (special_cfg == 2'd0) ? 3'd2 : 3'd6;
				default: bank = (special_cfg == 2'd1) ? 3'd7 : 3'd3;
			endcase
		end else begin
			case (addr[15:14])
				2'd0:    rom_sel = 1'b1;
				2'd1:    bank = BANK_SCREEN;
				2'd2:    bank = BANK_MID;
				default: bank = page_7ffd[2:0];   // Switchable top bank
			endcase
		end
	end

	always_comb begin
		ram_addr       = '0;
		ram_addr[13:0] = addr[13:0];    // Offset inside the 16K page
		if (rom_sel) begin
			ram_addr[ROM_BASE_BIT] = 1'b1;
			ram_addr[17:14]        = rom_page;
		end else begin
			ram_addr[16:14] = bank;
		end
	end

	// ROM area is read only unless RAM is mapped there
	assign ram_we = mem_req & wr & (special | addr[15] | addr[14]);

endmodule

/* logic/sound_mixer.sv */
// Beeper and DAC audio mix

`timescale 1ns/1ns

module sound_mixer
	import zx_bus_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,

	input  cpu_data_t dac_l0,
	input  cpu_data_t dac_l1,
	input  cpu_data_t dac_r0,
	input  cpu_data_t dac_r1,
	input  logic      ear_out,
	input  logic      mic_out,

	output audio_t    audio_l,
	output audio_t    audio_r
);

	// Peak is 14304, well inside 15 bits
	function automatic audio_t channel_mix(input cpu_data_t dac_a, input cpu_data_t dac_b,
		input logic ear, input logic mic);
		channel_mix = (audio_t'(dac_a) << DAC_SHIFT) + (audio_t'(dac_b) << DAC_SHIFT)
			+ (audio_t'(ear) << EAR_SHIFT) + (audio_t'(mic) << MIC_SHIFT);
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= channel_mix(dac_l0, dac_l1, ear_out, mic_out);
			audio_r <= channel_mix(dac_r0, dac_r1, ear_out, mic_out);   // Beeper on both
		end
	end

endmodule

/* logic/zx_bus_pkg.sv */
// ZX bus and audio definitions

package zx_bus_pkg;

	// ========================================================================
	// Bus widths
	// ========================================================================

	typedef logic [15:0] cpu_addr_t;   // Z80 address
	typedef logic [7:0]  cpu_data_t;   // Z80 data byte

	// ULA side
	typedef logic [2:0]  border_t;     // Border colour index

	// Audio output, unsigned
	typedef logic [14:0] audio_t;

	// ========================================================================
	// I/O port decode
	// ========================================================================

	// ULA answers any even port
	localparam int PORT_ULA_BIT = 0;

	// Low address byte of the DAC ports
	localparam cpu_data_t PORT_COVOX = 8'hFB;   // Covox, all four latches
	localparam cpu_data_t PORT_SD_A  = 8'h0F;   // SounDrive left 0
	localparam cpu_data_t PORT_SD_B  = 8'h1F;   // SounDrive left 1
	localparam cpu_data_t PORT_SD_C  = 8'h4F;   // SounDrive right 0
	localparam cpu_data_t PORT_SD_D  = 8'h5F;   // SounDrive right 1

	// ========================================================================
	// Mix scaling
	// ========================================================================

	// Two shifted DAC bytes plus both beeper bits stay below 2^15
	localparam int DAC_SHIFT = 4;
	localparam int EAR_SHIFT = 12;      // Beeper, loudest term
	localparam int MIC_SHIFT = 11;

endpackage

/* logic/zx_io_top.sv */
// ZX Spectrum I/O and paging core

`timescale 1ns/1ns

module zx_io_top
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  mem_mode_t mem_mode,

	// Z80 bus, active high levels
	input  cpu_addr_t addr,
	input  cpu_data_t data,
	input  logic      mem_req,
	input  logic      io_req,
	input  logic      rd,
	input  logic      wr,
	input  logic      m1,

	// RAM side
	output ram_addr_t ram_addr,
	output logic      ram_we,

	// ULA
	output border_t   border,
	output logic      ear_out,
	output logic      mic_out,

	output audio_t    audio_l,
	output audio_t    audio_r
);

	logic      io_write_pulse;
	cpu_data_t dac_l0;
	cpu_data_t dac_l1;
	cpu_data_t dac_r0;
	cpu_data_t dac_r1;

	// ========================================================================
	// Blocks
	// ========================================================================

	io_ports u_io_ports (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.addr           (addr),
		.data           (data),
		.io_req         (io_req),
		.wr             (wr),
		.m1             (m1),
		.io_write_pulse (io_write_pulse),
		.border         (border),
		.ear_out        (ear_out),
		.mic_out        (mic_out),
		.dac_l0         (dac_l0),
		.dac_l1         (dac_l1),
		.dac_r0         (dac_r0),
		.dac_r1         (dac_r1)
	);

	memory_pager u_memory_pager (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.mem_mode       (mem_mode),
		.addr           (addr),
		.data           (data),
		.mem_req        (mem_req),
		.wr             (wr),
		.io_write_pulse (io_write_pulse),   // Shares the ULA write edge
		.ram_addr       (ram_addr),
		.ram_we         (ram_we)
	);

	sound_mixer u_sound_mixer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dac_l0  (dac_l0),
		.dac_l1  (dac_l1),
		.dac_r0  (dac_r0),
		.dac_r1  (dac_r1),
		.ear_out (ear_out),
		.mic_out (mic_out),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

/* logic/zx_mem_pkg.sv */
// ZX memory model definitions

package zx_mem_pkg;

	// ========================================================================
	// Types
	// ========================================================================

	// 4M byte window seen by the RAM controller
	typedef logic [21:0] ram_addr_t;

	typedef logic [2:0]  mem_mode_t;    // Machine model code
	typedef logic [2:0]  bank_t;        // 16K RAM bank
	typedef logic [3:0]  rom_bank_t;    // 16K ROM page

	// ========================================================================
	// Machine models
	// ========================================================================

	// Codes follow the board's memory menu order
	localparam mem_mode_t MODE_128K  = 3'd0;
	localparam mem_mode_t MODE_48K   = 3'd3;
	localparam mem_mode_t MODE_PLUS3 = 3'd4;

	// ========================================================================
	// RAM address layout
	// ========================================================================

	// Upper half of the window holds the ROM images
	localparam int ROM_BASE_BIT = 21;

	// Banks fixed in the normal paging layout
	localparam bank_t BANK_SCREEN = 3'd5;   // 4000-7FFF
	localparam bank_t BANK_MID    = 3'd2;   // 8000-BFFF

	// RAM pages are bank * 16K, ROM pages sit above ROM_BASE_BIT
	// with the same 16K stride, so only four page bits are needed
	// between the offset and the ROM flag.

endpackage

/* tb.f */
logic/zx_bus_pkg.sv
logic/zx_mem_pkg.sv
logic/io_ports.sv
logic/memory_pager.sv
logic/sound_mixer.sv
logic/zx_io_top.sv
testbench/zx_io_properties.sv
testbench/tb_zx_io.sv

/* testbench/tb_zx_io.sv */
// ZX I/O core testbench

`timescale 1ns/1ns

module tb_zx_io
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
();

	localparam int ROW_MAX    = 128;
	localparam int KIND_RESET = 0;
	localparam int KIND_IO    = 1;
	localparam int KIND_MEM   = 2;
	localparam int KIND_AUDIO = 3;

	logic      clk_sys;
	logic      reset;
	mem_mode_t mem_mode;
	cpu_addr_t addr;
	cpu_data_t data;
	logic      mem_req;
	logic      io_req;
	logic      rd;
	logic      wr;
	logic      m1;
	ram_addr_t ram_addr;
	logic      ram_we;
	border_t   border;
	logic      ear_out;
	logic      mic_out;
	audio_t    audio_l;
	audio_t    audio_r;

	// ========================================================================
	// Stimulus table
	// ========================================================================

	string      row_name  [ROW_MAX];
	int         row_kind  [ROW_MAX];
	cpu_addr_t  row_addr  [ROW_MAX];
	cpu_data_t  row_data  [ROW_MAX];   // Write data, model code or probe wr
	ram_addr_t  row_exp_a [ROW_MAX];   // RAM address or left audio
	audio_t     row_exp_b [ROW_MAX];   // Write enable or right audio
	logic [4:0] row_exp_c [ROW_MAX];   // Border, ear, mic
	int         row_count;

	// Expected latch state while the table is built
	border_t   ref_border;
	logic      ref_ear;
	logic      ref_mic;
	cpu_data_t ref_dac [4];            // l0, l1, r0, r1

	logic [31:0] rng_state;
	int          io_errors;
	int          mem_errors;
	int          audio_errors;
	int          cycle_count;
	int          cycle_limit;

	zx_io_top UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		xorshift32 = y ^ (y << 5);
	endfunction

	function automatic ram_addr_t bank_addr(input int bank, input cpu_addr_t a);
		bank_addr = ram_addr_t'(bank * 16384 + int'(a[13:0]));
	endfunction

	// ROM pages sit above bit 21 with the RAM bank stride
	function automatic ram_addr_t rom_addr(input int page, input cpu_addr_t a);
		rom_addr = ram_addr_t'((1 << 21) + page * 16384 + int'(a[13:0]));
	endfunction

	function automatic audio_t mix_expect(input cpu_data_t a, input cpu_data_t b,
		input logic ear, input logic mic);
		int sum;
		sum = int'(a) * 16 + int'(b) * 16 + int'(ear) * 4096 + int'(mic) * 2048;
		mix_expect = audio_t'(sum);
	endfunction

	task automatic put_row(input string name, input int kind, input cpu_addr_t a,
		input cpu_data_t d, input ram_addr_t exp_a, input audio_t exp_b);
		row_name[row_count]  = name;
		row_kind[row_count]  = kind;
		row_addr[row_count]  = a;
		row_data[row_count]  = d;
		row_exp_a[row_count] = exp_a;
		row_exp_b[row_count] = exp_b;
		row_exp_c[row_count] = {ref_border, ref_ear, ref_mic};
		row_count++;
	endtask

	task automatic reset_row(input string name, input mem_mode_t mode);
		ref_border = '0;
		ref_ear    = 1'b0;
		ref_mic    = 1'b0;
		for (int j = 0; j < 4; j++)
			ref_dac[j] = '0;
		put_row(name, KIND_RESET, '0, cpu_data_t'(mode), '0, '0);
	endtask

	task automatic write_row(input string name, input cpu_addr_t a, input cpu_data_t d);
		if (!a[0]) begin                // Any even port is the ULA
			ref_border = d[2:0];
			ref_ear    = d[4];
			ref_mic    = d[3];
		end
		case (a[7:0])
			8'hFB: begin
				for (int j = 0; j < 4; j++)
					ref_dac[j] = d;
			end
			8'h0F:   ref_dac[0] = d;
			8'h1F:   ref_dac[1] = d;
			8'h4F:   ref_dac[2] = d;
			8'h5F:   ref_dac[3] = d;
			default: ;
		endcase
		put_row(name, KIND_IO, a, d, '0, '0);
	endtask

	task automatic probe_row(input string name, input cpu_addr_t a, input logic write,
		input ram_addr_t exp_addr, input logic exp_we);
		put_row(name, KIND_MEM, a, {7'b0, write}, exp_addr, audio_t'(exp_we));
	endtask

	task automatic audio_row(input string name);
		put_row(name, KIND_AUDIO, '0, '0,
			ram_addr_t'(mix_expect(ref_dac[0], ref_dac[1], ref_ear, ref_mic)),
			mix_expect(ref_dac[2], ref_dac[3], ref_ear, ref_mic));
	endtask

	task automatic build_table();
		int        layout [4][4] = '{'{0, 1, 2, 3}, '{4, 5, 6, 7}, '{4, 5, 6, 3}, '{4, 7, 6, 3}};
		cpu_data_t dac_port [5] = '{8'hFB, 8'h0F, 8'h1F, 8'h4F, 8'h5F};
		cpu_data_t port;

		// ====================================================================
		// 128K model
		// ====================================================================
		reset_row("reset_128k", MODE_128K);
		audio_row("audio_after_reset_128k");
		probe_row("rom_128k", 16'h0000, 1'b0, rom_addr(2, 16'h0000), 1'b0);
		probe_row("top_bank0_128k", 16'hC000, 1'b0, bank_addr(0, 16'hC000), 1'b0);
		probe_row("screen_bank_write", 16'h4123, 1'b1, bank_addr(5, 16'h4123), 1'b1);
		probe_row("mid_bank_write", 16'h8FFF, 1'b1, bank_addr(2, 16'h8FFF), 1'b1);
		probe_row("rom_write_blocked", 16'h1234, 1'b1, rom_addr(2, 16'h1234), 1'b0);
		write_row("7ffd_bank3_rom1", 16'h7FFD, 8'h13);
		probe_row("top_bank3", 16'hC005, 1'b1, bank_addr(3, 16'hC005), 1'b1);
		probe_row("rom1_128k", 16'h2000, 1'b0, rom_addr(3, 16'h2000), 1'b0);
		write_row("7ffd_partial_decode", 16'h3FFD, 8'h07);   // A14 ignored off +3
		probe_row("top_bank7", 16'hFFFF, 1'b0, bank_addr(7, 16'hFFFF), 1'b0);
		probe_row("rom0_128k", 16'h3FFF, 1'b0, rom_addr(2, 16'h3FFF), 1'b0);
		write_row("7ffd_lock", 16'h7FFD, 8'h26);
		probe_row("top_bank6_locked", 16'hC100, 1'b0, bank_addr(6, 16'hC100), 1'b0);
		write_row("7ffd_while_locked", 16'h7FFD, 8'h11);
		probe_row("top_bank6_kept", 16'hC100, 1'b0, bank_addr(6, 16'hC100), 1'b0);
		probe_row("rom0_kept", 16'h0000, 1'b0, rom_addr(2, 16'h0000), 1'b0);
		reset_row("reset_128k_unlock", MODE_128K);
		write_row("7ffd_after_unlock", 16'h7FFD, 8'h04);
		probe_row("top_bank4", 16'hC000, 1'b0, bank_addr(4, 16'hC000), 1'b0);

		// ====================================================================
		// 48K model, ULA port and DACs
		// ====================================================================
		reset_row("reset_48k", MODE_48K);
		probe_row("rom_48k", 16'h0100, 1'b0, rom_addr(11, 16'h0100), 1'b0);
		write_row("7ffd_48k_ignored", 16'h7FFD, 8'h17);
		probe_row("top_bank0_48k", 16'hC000, 1'b1, bank_addr(0, 16'hC000), 1'b1);
		probe_row("rom_48k_kept", 16'h0000, 1'b0, rom_addr(11, 16'h0000), 1'b0);
		write_row("ula_border5_ear", 16'h00FE, 8'h15);
		audio_row("audio_ear");
		write_row("ula_border2_mic", 16'hA0FE, 8'h0A);
		audio_row("audio_mic");
		write_row("ula_border7_both", 16'h12FC, 8'h1F);
		audio_row("audio_both");
		for (int n = 0; n < 10; n++) begin
			rng_state = xorshift32(rng_state);
			port      = dac_port[n % 5];   // Covox, then each SounDrive latch
			write_row($sformatf("dac_%02h_%0d", port, n), {8'h00, port}, rng_state[15:8]);
			audio_row($sformatf("audio_dac_%0d", n));
		end
		write_row("ula_beeper_off", 16'h00FE, 8'h03);
		audio_row("audio_dac_only");

		// ====================================================================
		// +3 model and the all-RAM layouts
		// ====================================================================
		reset_row("reset_plus3", MODE_PLUS3);
		audio_row("audio_after_reset_plus3");
		probe_row("rom_plus3", 16'h0000, 1'b0, rom_addr(4, 16'h0000), 1'b0);
		write_row("7ffd_a14_low_ignored", 16'h3FFD, 8'h03);
		probe_row("top_bank0_plus3", 16'hC000, 1'b0, bank_addr(0, 16'hC000), 1'b0);
		write_row("7ffd_plus3", 16'h7FFD, 8'h11);
		probe_row("top_bank1_plus3", 16'hE000, 1'b0, bank_addr(1, 16'hE000), 1'b0);
		probe_row("rom_plus3_page5", 16'h0000, 1'b0, rom_addr(5, 16'h0000), 1'b0);
		write_row("1ffd_rom_high", 16'h1FFD, 8'h04);
		probe_row("rom_plus3_page7", 16'h0000, 1'b0, rom_addr(7, 16'h0000), 1'b0);
		probe_row("rom_plus3_write_blocked", 16'h0000, 1'b1, rom_addr(7, 16'h0000), 1'b0);
		for (int k = 0; k < 4; k++) begin
			write_row($sformatf("1ffd_special_%0d", k), 16'h1FFD, cpu_data_t'(2 * k + 1));
			for (int q = 0; q < 4; q++)
				probe_row($sformatf("special_%0d_quarter_%0d", k, q),
					cpu_addr_t'(q * 16384 + q), 1'b1,
					bank_addr(layout[k][q], cpu_addr_t'(q)), 1'b1);
		end
	endtask

	task automatic show_mismatch(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("FAILED %s %s: expected %0h, actual %0h", name, what, expected, actual);
	endtask

	task automatic check_row(input int i);
		if (row_kind[i] == KIND_MEM) begin
			if (ram_addr !== row_exp_a[i]) begin
				show_mismatch(row_name[i], "ram_addr", 32'(row_exp_a[i]), 32'(ram_addr));
				mem_errors++;
			end
			if (ram_we !== row_exp_b[i][0]) begin
				show_mismatch(row_name[i], "ram_we", 32'(row_exp_b[i][0]), 32'(ram_we));
				mem_errors++;
			end
		end
		if (row_kind[i] == KIND_AUDIO) begin
			if (audio_l !== row_exp_a[i][14:0]) begin
				show_mismatch(row_name[i], "audio_l", 32'(row_exp_a[i][14:0]), 32'(audio_l));
				audio_errors++;
			end
			if (audio_r !== row_exp_b[i]) begin
				show_mismatch(row_name[i], "audio_r", 32'(row_exp_b[i]), 32'(audio_r));
				audio_errors++;
			end
		end
		// Border, ear and mic after writes and at audio points
		if (row_kind[i] == KIND_IO || row_kind[i] == KIND_AUDIO) begin
			if ({border, ear_out, mic_out} !== row_exp_c[i]) begin
				show_mismatch(row_name[i], "ula", 32'(row_exp_c[i]),
					32'({border, ear_out, mic_out}));
				io_errors++;
			end
		end
	endtask

	// Starts and ends on a falling edge
	task automatic run_row(input int i);
		if (row_kind[i] == KIND_RESET) begin
			reset    = 1'b1;
			mem_mode = row_data[i][2:0];
			repeat (4) @(negedge clk_sys);
			reset = 1'b0;
			@(negedge clk_sys);
		end else begin
			addr = row_addr[i];
			data = row_data[i];
			if (row_kind[i] == KIND_IO) begin
				io_req = 1'b1;
				wr     = 1'b1;
			end else if (row_kind[i] == KIND_MEM) begin
				mem_req = 1'b1;
				wr      = row_data[i][0];
			end
			@(negedge clk_sys);
			if (row_kind[i] == KIND_IO)
				data = ~row_data[i];      // Second cycle of a held write must not latch
			@(negedge clk_sys);
			check_row(i);
			mem_req = 1'b0;
			io_req  = 1'b0;
			wr      = 1'b0;
			@(negedge clk_sys);           // Idle cycle so the next write has an edge
		end
	endtask

	initial begin
		reset        = 1'b1;
		mem_mode     = MODE_128K;
		addr         = '0;
		data         = '0;
		mem_req      = 1'b0;
		io_req       = 1'b0;
		rd           = 1'b0;
		wr           = 1'b0;
		m1           = 1'b0;
		io_errors    = 0;
		mem_errors   = 0;
		audio_errors = 0;
		row_count    = 0;
		rng_state    = 32'hd69b_e1bc;
		build_table();
		cycle_limit = row_count * 8 + 200;
		@(negedge clk_sys);
		for (int i = 0; i < row_count; i++)
			run_row(i);
		$display("Errors: %0d port, %0d memory, %0d audio over %0d rows",
			io_errors, mem_errors, audio_errors, row_count);
		if (io_errors + mem_errors + audio_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		cycle_count = 0;
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the table did not finish", cycle_count);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* testbench/zx_io_properties.sv */
// Paging and port write assertions

`timescale 1ns/1ns

module zx_io_properties
	import zx_bus_pkg::*;
(
	input logic      clk_sys,
	input logic      reset,
	input logic      mem_req,
	input logic      wr,
	input logic      ram_we,
	input logic      page_disable,
	input cpu_data_t page_7ffd,
	input logic      io_write_pulse   // Driven by io_ports
);

	// RAM writes only come from a bus write cycle
	we_needs_bus_write: assert property (@(posedge clk_sys) ram_we |-> (mem_req && wr))
		else $error("ram_we high without mem_req and wr");

	// Locked paging holds until the next reset
	lock_holds_7ffd: assert property (@(posedge clk_sys) disable iff (reset)
		page_disable |=> $stable(page_7ffd))
		else $error("page_7ffd changed while paging was locked");

	pulse_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		io_write_pulse |=> !io_write_pulse)
		else $error("io_write_pulse high on two cycles in a row");

endmodule

// The pager sees the io_ports write pulse on its own input
bind memory_pager zx_io_properties u_properties (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.mem_req        (mem_req),
	.wr             (wr),
	.ram_we         (ram_we),
	.page_disable   (page_disable),
	.page_7ffd      (page_7ffd),
	.io_write_pulse (io_write_pulse)
);
